// ==== verilog/gp_settings.svh ====
// constants shared by the scan-out prefetcher
// a beat carries four pixel words and a buffer half holds exactly two beats
// address layout is zeros, frame, y, x/8, two zero bits, from the top down
// line widths are limited to 10 bits and must be multiples of 8

`ifndef GP_SETTINGS_SVH
`define GP_SETTINGS_SVH

// data path widths
`define GP_BEAT_W 128
`define GP_WORD_W 32

// ping-pong store
`define GP_BUF_WORDS 16
`define GP_HALF_WORDS 8

// DRAM read address layout
`define GP_ADDR_W 31
`define GP_FRAME_W 6
`define GP_Y_W 10
`define GP_XB_W 7

// line width
`define GP_WIDTH_W 10
`define GP_DEFAULT_WIDTH 10'd800

`endif

// ==== verilog/gp_pkg.sv ====
// types shared between decode, fetch and pixel buffer
// command word is 32 bits, opcode always in the top two bits

`include "gp_settings.svh"

package gp_pkg;

   // command kinds, code 0 is ignored by the decoder
   typedef enum logic [1:0] {
      GP_OP_START = 2'd1,
      GP_OP_WIDTH = 2'd2,
      GP_OP_ABORT = 2'd3
   } gp_opcode_e;

   // ----------------------------------------
   // command word views
   // ----------------------------------------
   typedef struct packed {
      gp_opcode_e                 opcode;
      logic [29-`GP_FRAME_W:0]    rsvd;
      logic [`GP_FRAME_W-1:0]     frame_idx;   // frame slot in DRAM
   } gp_cmd_start_s;

   typedef struct packed {
      gp_opcode_e                 opcode;
      logic [29-`GP_WIDTH_W:0]    rsvd;
      logic [`GP_WIDTH_W-1:0]     width;       // pixels per line
   } gp_cmd_width_s;

   typedef union packed {
      gp_cmd_start_s start_v;
      gp_cmd_width_s width_v;
   } gp_cmd_u;

   // decode to fetch
   typedef struct packed {
      logic                       start;       // one-cycle pulse
      logic                       abort;       // one-cycle pulse
      logic [`GP_FRAME_W-1:0]     frame_idx;
      logic [`GP_WIDTH_W-1:0]     width;
   } gp_frame_s;

   // fetch to pixel buffer
   typedef struct packed {
      logic beat_we;      // beat data valid this cycle
      logic half_sel;     // target half of the beat
      logic beat_idx;     // 0 = words 0..3, 1 = words 4..7
      logic half_done;    // cycle after beat 1
      logic running;      // level, frame in progress
   } gp_fetch_s;

endpackage

// ==== verilog/gp_cmd_decode.sv ====
// command word decoder
// start and abort leave as one-cycle pulses one cycle after cmd_valid
// frame index and line width are held until the next matching command
// a width command takes effect at the next start, not mid-frame

`include "gp_settings.svh"

module gp_cmd_decode (
   input  logic              clk,
   input  logic              rst,
   input  gp_pkg::gp_cmd_u   cmd,
   input  logic              cmd_valid,
   output gp_pkg::gp_frame_s frame
);

   gp_pkg::gp_opcode_e op;
   logic               is_width;

   // opcode sits in the same place in both views
   assign op       = cmd.start_v.opcode;
   assign is_width = cmd_valid && (op == gp_pkg::GP_OP_WIDTH);

   // ----------------------------------------
   // command register
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         frame.start     <= 1'b0;
         frame.abort     <= 1'b0;
         frame.frame_idx <= '0;
         frame.width     <= `GP_DEFAULT_WIDTH;
      end else begin
         frame.start <= 1'b0;   // pulses by default
         frame.abort <= 1'b0;
         if (cmd_valid) begin
            case (op)
               gp_pkg::GP_OP_START: begin
                  frame.start     <= 1'b1;
                  frame.frame_idx <= cmd.start_v.frame_idx;
               end
               gp_pkg::GP_OP_WIDTH: begin
                  frame.width <= cmd.width_v.width;
               end
               gp_pkg::GP_OP_ABORT: begin
                  frame.abort <= 1'b1;
               end
               default: begin
                  frame.start <= 1'b0;   // code 0, nothing to do
               end
            endcase
         end
      end
   end

   // widths must be whole bursts of 8 pixels
   a_width_legal: assert property (
      @(posedge clk) disable iff (rst)
      is_width |-> (cmd.width_v.width >= `GP_WIDTH_W'(8)) &&
                   (cmd.width_v.width[2:0] == 3'd0)
   );

endmodule

// ==== verilog/gp_burst_fetch.sv ====
// burst fetch engine, one 8-pixel burst outstanding at a time
// af_wr_en holds with a steady address until the address FIFO takes it
// beats owed by an aborted burst are counted and dropped on arrival
// y wraps at 10 bits; frame height is left to the display side

`include "gp_settings.svh"

module gp_burst_fetch (
   input  logic                   clk,
   input  logic                   rst,
   input  gp_pkg::gp_frame_s      frame,
   input  logic [1:0]             half_free,
   input  logic                   af_full,
   output logic                   af_wr_en,
   output logic [`GP_ADDR_W-1:0]  af_addr,
   input  logic                   rdf_valid,
   input  logic [`GP_BEAT_W-1:0]  rdf_data,
   output gp_pkg::gp_fetch_s      fetch,
   output logic [`GP_BEAT_W-1:0]  beat
);

   localparam int FIELD_W = `GP_FRAME_W + `GP_Y_W + `GP_XB_W + 2;

   typedef enum logic [2:0] {
      S_IDLE,
      S_REQ,
      S_BEAT0,
      S_BEAT1,
      S_WAIT
   } state_e;

   state_e                  state;
   logic [`GP_WIDTH_W-1:0]  x;
   logic [`GP_Y_W-1:0]      y;
   logic [`GP_FRAME_W-1:0]  cur_frame;
   logic [`GP_WIDTH_W-1:0]  cur_width;
   logic                    half;        // half the current burst fills
   logic [`GP_WIDTH_W:0]    x_next;
   logic                    line_end;
   logic                    accept;
   logic                    take;
   logic [1:0]              owed;        // beats still due for this burst
   logic [2:0]              stale;
   logic [2:0]              stale_next;

   assign af_wr_en = (state == S_REQ);
   assign af_addr  = {{(`GP_ADDR_W - FIELD_W){1'b0}}, cur_frame, y,
                      x[`GP_WIDTH_W-1 -: `GP_XB_W], 2'b00};

   assign accept   = af_wr_en && !af_full;
   assign take     = rdf_valid && (stale == 3'd0) &&
                     (state == S_BEAT0 || state == S_BEAT1);
   assign x_next   = {1'b0, x} + (`GP_WIDTH_W+1)'(8);
   assign line_end = (x_next >= {1'b0, cur_width});

   // ----------------------------------------
   // burst FSM and x/y walk
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         state <= S_IDLE;
         x     <= '0;
         y     <= '0;
         half  <= 1'b0;
      end else if (frame.abort) begin
         state <= S_IDLE;
      end else begin
         case (state)
            S_IDLE: if (frame.start) begin
               state <= S_REQ;
               x     <= '0;
               y     <= '0;
               half  <= 1'b0;   // always begin on half 0
            end
            S_REQ: if (accept) begin
               state <= S_BEAT0;
               if (line_end) begin
                  x <= '0;
                  y <= y + 1'b1;
               end else begin
                  x <= x_next[`GP_WIDTH_W-1:0];
               end
            end
            S_BEAT0: if (take) state <= S_BEAT1;
            S_BEAT1: if (take) begin
               half  <= ~half;
               state <= half_free[~half] ? S_REQ : S_WAIT;
            end
            S_WAIT: if (half_free[half]) state <= S_REQ;
            default: state <= S_IDLE;
         endcase
      end
   end

   // frame and width are sampled once per frame
   always_ff @(posedge clk) begin
      if (state == S_IDLE && frame.start) begin
         cur_frame <= frame.frame_idx;
         cur_width <= frame.width;
      end
   end

   // ----------------------------------------
   // beats to the pixel buffer
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (rst || frame.abort) begin
         fetch <= '0;
      end else begin
         fetch.beat_we   <= take;
         fetch.half_done <= fetch.beat_we & fetch.beat_idx;
         if (take) begin
            fetch.half_sel <= half;   // held through half_done
            fetch.beat_idx <= (state == S_BEAT1);
         end
         if (state == S_IDLE && frame.start) fetch.running <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (take) beat <= rdf_data;
   end

   // ----------------------------------------
   // leftover beats after abort
   // ----------------------------------------
   always_comb begin
      case (state)
         S_REQ:   owed = accept ? 2'd2 : 2'd0;
         S_BEAT0: owed = 2'd2;
         S_BEAT1: owed = 2'd1;
         default: owed = 2'd0;
      endcase
   end

   always_comb begin
      stale_next = stale;
      if (rdf_valid && stale != 3'd0) stale_next = stale_next - 3'd1;
      if (frame.abort) stale_next = stale_next + {1'b0, owed} - {2'b00, take};
   end

   always_ff @(posedge clk) begin
      if (rst) stale <= 3'd0;
      else     stale <= stale_next;
   end

   a_addr_hold: assert property (
      @(posedge clk) disable iff (rst)
      af_wr_en && af_full && !frame.abort |=> af_wr_en && $stable(af_addr)
   );

   // a beat not owed to an aborted burst must find the FSM waiting for it
   a_beat_in_state: assert property (
      @(posedge clk) disable iff (rst)
      rdf_valid && (stale == 3'd0) |-> (state == S_BEAT0 || state == S_BEAT1)
   );

endmodule

// ==== verilog/gp_pixel_buffer.sv ====
// ping-pong pixel store, two halves of eight words
// reader waits for half 0, then gives one word per cycle
// pixel is only meaningful while reading is high and stall is low
// dropping fetch.running empties the store and parks the reader

`include "gp_settings.svh"

module gp_pixel_buffer (
   input  logic                   clk,
   input  logic                   rst,
   input  gp_pkg::gp_fetch_s      fetch,
   input  logic [`GP_BEAT_W-1:0]  beat,
   output logic [1:0]             half_free,
   output logic [`GP_WORD_W-1:0]  pixel,
   output logic                   stall
);

   localparam int PTR_W      = $clog2(`GP_BUF_WORDS);
   localparam int HALF_W     = $clog2(`GP_HALF_WORDS);
   localparam int BEAT_WORDS = `GP_BEAT_W / `GP_WORD_W;

   logic [`GP_WORD_W-1:0] mem [`GP_BUF_WORDS];
   logic [1:0]            written;     // per half, filled and not yet left
   logic [PTR_W-1:0]      rd_ptr;
   logic                  rd_active;
   logic                  reading;
   logic                  at_last;
   logic                  other_ready;
   logic                  advance;
   logic [PTR_W-1:0]      wr_base;

   // ----------------------------------------
   // write side
   // ----------------------------------------
   assign wr_base = {fetch.half_sel, fetch.beat_idx, {(PTR_W-2){1'b0}}};

   always_ff @(posedge clk) begin
      if (fetch.beat_we) begin
         for (int i = 0; i < BEAT_WORDS; i++) begin
            mem[wr_base + PTR_W'(i)] <= beat[i*`GP_WORD_W +: `GP_WORD_W];
         end
      end
   end

   // ----------------------------------------
   // read side
   // ----------------------------------------
   assign reading     = rd_active & fetch.running;
   assign at_last     = (rd_ptr[HALF_W-1:0] == HALF_W'(`GP_HALF_WORDS - 1));
   assign other_ready = written[~rd_ptr[PTR_W-1]];
   assign advance     = reading && (!at_last || other_ready);

   assign stall     = reading && at_last && !other_ready;
   assign half_free = ~written;
   assign pixel     = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (rst || !fetch.running) begin
         rd_active <= 1'b0;
         rd_ptr    <= '0;
         written   <= 2'b00;
      end else begin
         // leaving a half hands it back to fetch
         if (advance && at_last) written[rd_ptr[PTR_W-1]] <= 1'b0;
         if (fetch.half_done) begin
            written[fetch.half_sel] <= 1'b1;
            if (!fetch.half_sel) rd_active <= 1'b1;   // first half starts the reader
         end
         if (advance) rd_ptr <= rd_ptr + 1'b1;       // wraps 15 -> 0
      end
   end

   // fetch must only target the half the reader is not in
   a_no_overwrite: assert property (
      @(posedge clk) disable iff (rst)
      fetch.beat_we && reading |-> fetch.half_sel != rd_ptr[PTR_W-1]
   );

endmodule

// ==== verilog/gp_scan_top.sv ====
// scan-out prefetcher top level
// address FIFO takes af_addr in cycles with af_wr_en high and af_full low
// read FIFO must deliver two beats per accepted address, in order
// pixel is a 32-bit word, valid on cycles the reader runs without stall

`include "gp_settings.svh"

module gp_scan_top (
   input  logic                   clk,
   input  logic                   rst,
   input  gp_pkg::gp_cmd_u        cmd,
   input  logic                   cmd_valid,
   input  logic                   af_full,
   output logic                   af_wr_en,
   output logic [`GP_ADDR_W-1:0]  af_addr,
   input  logic                   rdf_valid,
   input  logic [`GP_BEAT_W-1:0]  rdf_data,
   output logic [`GP_WORD_W-1:0]  pixel,
   output logic                   stall
);

   gp_pkg::gp_frame_s      frame;
   gp_pkg::gp_fetch_s      fetch;
   logic [`GP_BEAT_W-1:0]  beat;
   logic [1:0]             half_free;

   gp_cmd_decode gp_cmd_decode_inst (
      .clk       (clk),
      .rst       (rst),
      .cmd       (cmd),
      .cmd_valid (cmd_valid),
      .frame     (frame)
   );

   gp_burst_fetch gp_burst_fetch_inst (
      .clk       (clk),
      .rst       (rst),
      .frame     (frame),
      .half_free (half_free),
      .af_full   (af_full),
      .af_wr_en  (af_wr_en),
      .af_addr   (af_addr),
      .rdf_valid (rdf_valid),
      .rdf_data  (rdf_data),
      .fetch     (fetch),
      .beat      (beat)
   );

   gp_pixel_buffer gp_pixel_buffer_inst (
      .clk       (clk),
      .rst       (rst),
      .fetch     (fetch),
      .beat      (beat),
      .half_free (half_free),
      .pixel     (pixel),
      .stall     (stall)
   );

endmodule

// ==== tests/gp_dram_model.sv ====
// behavioral DRAM read side for the scan-out testbench
// address FIFO is unbounded; af_full is random or forced, never real back-pressure
// two beats per accepted address, after 1 to max_delay idle cycles
// pixel word i of address A reads back as A*8+i

`include "gp_settings.svh"

module gp_dram_model (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   af_wr_en,
   input  logic [`GP_ADDR_W-1:0]  af_addr,
   output logic                   af_full,
   output logic                   rdf_valid,
   output logic [`GP_BEAT_W-1:0]  rdf_data,
   input  logic [7:0]             full_pct,    // chance of af_full per cycle
   input  logic                   force_full,
   input  logic [7:0]             max_delay
);

   timeunit 1ns;
   timeprecision 100ps;

   logic [`GP_ADDR_W-1:0] addr_q[$];
   logic [`GP_ADDR_W-1:0] cur_addr;
   logic                  busy;
   int                    delay;
   int                    beat_no;

   initial begin
      af_full   = 1'b0;
      rdf_valid = 1'b0;
      rdf_data  = '0;
      busy      = 1'b0;
      delay     = 0;
      beat_no   = 0;
   end

   always @(posedge clk) begin
      logic                  nxt_valid;
      logic [`GP_BEAT_W-1:0] nxt_data;
      logic                  nxt_full;
      nxt_valid = 1'b0;
      nxt_data  = '0;
      if (rst) begin
         addr_q.delete();
         busy = 1'b0;
      end else begin
         if (af_wr_en && !af_full) addr_q.push_back(af_addr);   // accepted this edge
         if (!busy && addr_q.size() > 0) begin
            cur_addr = addr_q.pop_front();
            busy     = 1'b1;
            beat_no  = 0;
            delay    = 1 + $urandom_range(int'(max_delay) - 1);
         end else if (busy) begin
            if (delay > 0) begin
               delay--;
            end else begin
               nxt_valid = 1'b1;
               for (int i = 0; i < 4; i++) begin
                  nxt_data[i*32 +: 32] = 32'(cur_addr) * 32'd8 + 32'(beat_no * 4 + i);
               end
               beat_no++;
               if (beat_no == 2) busy = 1'b0;
            end
         end
      end
      nxt_full = force_full || ($urandom_range(99) < int'(full_pct));
      #1;
      rdf_valid = nxt_valid;
      rdf_data  = nxt_data;
      af_full   = rst ? 1'b0 : nxt_full;
   end

endmodule

// ==== tests/gp_scan_tb.sv ====
// directed testbench for the scan-out prefetcher
// pixel capture peeks at the buffer's reading level, not a top-level port
// expected addresses and pixels are rebuilt from the address layout

`include "gp_settings.svh"

module gp_scan_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int TIMEOUT = 40000;

   logic                  clk;
   logic                  rst;
   gp_pkg::gp_cmd_u       cmd;
   logic                  cmd_valid;
   logic                  af_full;
   logic                  af_wr_en;
   logic [`GP_ADDR_W-1:0] af_addr;
   logic                  rdf_valid;
   logic [`GP_BEAT_W-1:0] rdf_data;
   logic [`GP_WORD_W-1:0] pixel;
   logic                  stall;
   logic [7:0]            full_pct;
   logic                  force_full;
   logic [7:0]            max_delay;

   logic [31:0]           pix_q[$];
   logic [`GP_ADDR_W-1:0] acc_q[$];
   logic                  hold_prev;
   logic [`GP_ADDR_W-1:0] prev_addr;
   int                    hold_cycles;
   int                    stall_cycles;
   int                    errors;
   int                    tests_run;
   int                    tests_failed;
   int                    cur_width;

   gp_scan_top gp_scan_top_inst (
      .clk       (clk),
      .rst       (rst),
      .cmd       (cmd),
      .cmd_valid (cmd_valid),
      .af_full   (af_full),
      .af_wr_en  (af_wr_en),
      .af_addr   (af_addr),
      .rdf_valid (rdf_valid),
      .rdf_data  (rdf_data),
      .pixel     (pixel),
      .stall     (stall)
   );

   gp_dram_model gp_dram_model_inst (
      .clk        (clk),
      .rst        (rst),
      .af_wr_en   (af_wr_en),
      .af_addr    (af_addr),
      .af_full    (af_full),
      .rdf_valid  (rdf_valid),
      .rdf_data   (rdf_data),
      .full_pct   (full_pct),
      .force_full (force_full),
      .max_delay  (max_delay)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // ----------------------------------------
   // monitors
   // ----------------------------------------
   always @(posedge clk) begin
      if (rst) begin
         hold_prev = 1'b0;
      end else begin
         if (gp_scan_top_inst.gp_pixel_buffer_inst.reading && !stall) pix_q.push_back(pixel);
         if (gp_scan_top_inst.gp_pixel_buffer_inst.reading && stall) begin
            stall_cycles++;
            // the held word must be the last of a half
            assert (pix_q.size() % 8 == 7) else begin
               $display("stall raised away from the end of a half, after %0d pixels",
                        pix_q.size());
               errors++;
            end
         end
         if (af_wr_en && !af_full) acc_q.push_back(af_addr);
         if (hold_prev && af_wr_en) begin
            assert (af_addr == prev_addr) else begin
               $display("mismatch at %0t: af_addr got %h expected %h", $time, af_addr,
                        prev_addr);
               errors++;
            end
         end
         hold_prev = af_wr_en && af_full;
         prev_addr = af_addr;
         if (hold_prev) hold_cycles++;
      end
   end

   // address of burst n from frame, y and x/8
   function automatic logic [`GP_ADDR_W-1:0] exp_addr(input int frame_k, input int width,
                                                       input int n);
      int per;
      per = width / 8;
      return `GP_ADDR_W'((frame_k << 19) | ((n / per) << 9) | ((n % per) << 2));
   endfunction

   // ----------------------------------------
   // helpers
   // ----------------------------------------
   task automatic send_cmd(input logic [31:0] word);
      @(posedge clk);
      #1;
      cmd       = word;
      cmd_valid = 1'b1;
      @(posedge clk);
      #1;
      cmd_valid = 1'b0;
   endtask

   task automatic start_frame(input int frame_k);
      pix_q.delete();
      acc_q.delete();
      hold_cycles  = 0;
      stall_cycles = 0;
      send_cmd({2'd1, 24'd0, 6'(frame_k)});
   endtask

   task automatic stop_frame();
      int cnt;
      send_cmd({2'd3, 30'd0});
      @(posedge clk);   // abort reaches the FSM here
      #1;
      cnt = 0;
      while (gp_dram_model_inst.busy && cnt < TIMEOUT) begin
         @(posedge clk);
         #1;
         cnt++;
      end
      assert (!gp_dram_model_inst.busy) else begin
         $display("timeout while waiting for the last read beats after abort");
         errors++;
      end
   endtask

   task automatic wait_pixels(input int n);
      int cnt;
      cnt = 0;
      while (pix_q.size() < n && cnt < TIMEOUT) begin
         @(posedge clk);
         cnt++;
      end
      #1;
      assert (pix_q.size() >= n) else begin
         $display("timeout while waiting for %0d pixels, only %0d arrived", n, pix_q.size());
         errors++;
      end
   endtask

   task automatic wait_addrs(input int n);
      int cnt;
      cnt = 0;
      while (acc_q.size() < n && cnt < TIMEOUT) begin
         @(posedge clk);
         cnt++;
      end
      #1;
      assert (acc_q.size() >= n) else begin
         $display("timeout while waiting for %0d accepted addresses", n);
         errors++;
      end
   endtask

   task automatic check_addrs(input int frame_k, input int n);
      logic [`GP_ADDR_W-1:0] want;
      for (int i = 0; i < n && i < acc_q.size(); i++) begin
         want = exp_addr(frame_k, cur_width, i);
         assert (acc_q[i] == want) else begin
            $display("mismatch at %0t: af_addr[%0d] got %h expected %h", $time, i,
                     acc_q[i], want);
            errors++;
         end
      end
   endtask

   task automatic check_stream(input int frame_k, input int n);
      logic [31:0] want;
      for (int i = 0; i < n && i < pix_q.size(); i++) begin
         want = 32'(exp_addr(frame_k, cur_width, i / 8)) * 32'd8 + 32'(i % 8);
         assert (pix_q[i] == want) else begin
            $display("mismatch at %0t: pixel[%0d] got %h expected %h", $time, i,
                     pix_q[i], want);
            errors++;
            break;   // later words are shifted too
         end
      end
   endtask

   task automatic report(input string name, input int err_before);
      tests_run++;
      if (errors > err_before) begin
         tests_failed++;
         $display("%s: FAIL", name);
      end else begin
         $display("%s: pass", name);
      end
   endtask

   // ----------------------------------------
   // directed tests
   // ----------------------------------------
   task automatic test_first_addrs();
      int e;
      e = errors;
      start_frame(5);
      wait_addrs(4);
      check_addrs(5, 4);
      stop_frame();
      report("first addresses", e);
   endtask

   task automatic test_two_lines();
      int e;
      e = errors;
      start_frame(3);
      wait_pixels(2 * cur_width);
      check_stream(3, 2 * cur_width);
      stop_frame();
      report("two line stream", e);
   endtask

   task automatic test_back_pressure();
      int e;
      int cnt;
      int stretch;
      e = errors;
      start_frame(7);
      wait_pixels(200);
      force_full = 1'b1;
      cnt = 0;
      do begin
         @(posedge clk);
         #1;
         cnt++;
      end while (!hold_prev && cnt < TIMEOUT);
      assert (hold_prev) else begin
         $display("no address request was held while af_full was forced");
         errors++;
      end
      hold_cycles = 0;
      stretch     = 10 + $urandom_range(30);
      repeat (stretch) @(posedge clk);
      #1;
      force_full = 1'b0;
      // request must stay up for the whole stretch
      assert (af_wr_en && hold_cycles == stretch) else begin
         $display("mismatch at %0t: held request cycles got %0d expected %0d", $time,
                  hold_cycles, stretch);
         errors++;
      end
      wait_pixels(2 * cur_width);
      check_stream(7, 2 * cur_width);
      stop_frame();
      report("back-pressure", e);
   endtask

   task automatic test_slow_reads();
      int e;
      e = errors;
      max_delay = 8'd30;
      start_frame(2);
      wait_pixels(256);
      check_stream(2, 256);
      assert (stall_cycles > 0) else begin
         $display("long read delays never raised stall");
         errors++;
      end
      stop_frame();
      max_delay = 8'd6;
      report("slow reads", e);
   endtask

   task automatic test_width_64();
      int e;
      e = errors;
      send_cmd({2'd2, 20'd0, 10'd64});
      cur_width = 64;
      start_frame(1);
      wait_addrs(20);
      check_addrs(1, 20);
      wait_pixels(256);
      check_stream(1, 256);
      stop_frame();
      report("width 64", e);
   endtask

   task automatic test_abort();
      int e;
      int cnt;
      e = errors;
      start_frame(9);
      wait_pixels(40);
      send_cmd({2'd3, 30'd0});
      cnt = 0;
      while ((af_wr_en || stall || gp_scan_top_inst.gp_pixel_buffer_inst.reading) &&
             cnt < 2) begin
         @(posedge clk);
         #1;
         cnt++;
      end
      assert (!af_wr_en && !stall && !gp_scan_top_inst.gp_pixel_buffer_inst.reading)
      else begin
         $display("af_wr_en, stall or the reader still active two cycles after abort");
         errors++;
      end
      start_frame(9);
      wait_addrs(2);
      check_addrs(9, 2);
      wait_pixels(32);
      check_stream(9, 32);
      stop_frame();
      report("abort and restart", e);
   endtask

   initial begin
      void'($urandom(32'h3dc8_c86e));
      rst          = 1'b1;
      cmd          = '0;
      cmd_valid    = 1'b0;
      full_pct     = 8'd20;
      force_full   = 1'b0;
      max_delay    = 8'd6;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      hold_cycles  = 0;
      stall_cycles = 0;
      cur_width    = 800;
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b0;
      test_first_addrs();
      test_two_lines();
      test_back_pressure();
      test_slow_reads();
      test_width_64();
      test_abort();
      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// ==== project.f ====
+incdir+verilog
verilog/gp_pkg.sv
verilog/gp_cmd_decode.sv
verilog/gp_burst_fetch.sv
verilog/gp_pixel_buffer.sv
verilog/gp_scan_top.sv
tests/gp_dram_model.sv
tests/gp_scan_tb.sv

// ==== Makefile ====
# Verilator build for the scan-out prefetcher

VERILATOR ?= verilator
TOP       ?= gp_scan_tb
RTL_TOP   ?= gp_scan_top
FILELIST  ?= project.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD)/V$(TOP): $(shell sed -n 's/^\([^+].*\)$$/\1/p' $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)

sim: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "Everything OK" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
